// ==== logic/e300_glue_config.svh ====
// ------------------------------------------------------------
// Widths are fixed by the AD9361 sample format; change with care
// Stage counts set the exact latency seen by software
// ------------------------------------------------------------
`ifndef E300_GLUE_CONFIG_SVH
`define E300_GLUE_CONFIG_SVH

// Transceiver I or Q sample width
`define E300_SAMPLE_WIDTH 12

// Packed sample word toward the core
`define E300_WORD_WIDTH 32

// Zero bits below each component in a word
`define E300_PAD_WIDTH 4

// Interrupt pulse length in bus_clk cycles
`define E300_STRETCH_CYCLES 8

// Synchronizer depths
`define E300_PPS_SYNC_STAGES 3
`define E300_STATUS_SYNC_STAGES 2

// Stream, press, release, PMU
`define E300_IRQ_WIDTH 4

`endif

// ==== logic/e300_glue_pkg.sv ====
// ------------------------------------------------------------
// Shared types for the bus-clock glue logic
// Field order in the structs matches the board wiring
// ------------------------------------------------------------
`default_nettype none

`include "e300_glue_config.svh"

package e300_glue_pkg;

  // One transceiver I or Q sample
  typedef logic [`E300_SAMPLE_WIDTH-1:0] sample_t;

  // One packed sample word on the core side
  typedef logic [`E300_WORD_WIDTH-1:0] word_t;

  // Interrupt vector
  // bit 0 stream, bit 1 press, bit 2 release, bit 3 PMU
  typedef logic [`E300_IRQ_WIDTH-1:0] irq_vec_t;

  // ------------------------------------------------------------
  // Grouped signals
  // ------------------------------------------------------------

  // Transceiver sample pair
  typedef struct packed {
    sample_t i;
    sample_t q;
  } iq_t;

  // Three-wire SPI master outputs, sen is active low
  typedef struct packed {
    logic sen;
    logic sclk;
    logic mosi;
  } spi_bus_t;

  // Reference loop status from the TCXO domain
  typedef struct packed {
    logic plllck;
    logic is_10meg;
    logic is_pps;
    logic reflck;
  } ref_status_t;

endpackage

`default_nettype wire

// ==== logic/button_irq.sv ====
// ------------------------------------------------------------
// onswitch is active low and expected to be debounced already
// No press is seen until the input has been high for 2 cycles
// ------------------------------------------------------------
`default_nettype none

`include "e300_glue_config.svh"

module button_irq (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic onswitch,
  output logic press_irq,
  output logic release_irq
);

  // Two previous samples of the switch, bit 0 is the newer one
  logic [1:0] onswitch_hist;

  // Lane 0 is press, lane 1 is release
  logic [1:0] edge_evt;
  logic [1:0] lane_irq;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      onswitch_hist <= 2'b00;
    end else begin
      onswitch_hist <= {onswitch_hist[0], onswitch};
    end
  end

  // ------------------------------------------------------------
  // Edge detection
  // ------------------------------------------------------------

  // Press pulls the line low after two high samples
  assign edge_evt[0] = ~onswitch & onswitch_hist[0] & onswitch_hist[1];

  // Release is the mirror image
  assign edge_evt[1] = onswitch & ~onswitch_hist[0] & ~onswitch_hist[1];

  // ------------------------------------------------------------
  // Pulse stretching
  // ------------------------------------------------------------

  // Stretch each event so a slow interrupt controller won't miss it
  for (genvar g = 0; g < 2; g++) begin : g_lane
    logic [`E300_STRETCH_CYCLES-1:0] stretch;

    always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
        stretch <= '0;
      end else begin
        stretch <= {stretch[`E300_STRETCH_CYCLES-2:0], edge_evt[g]};
      end
    end

    // High while the event bit is anywhere in the register
    assign lane_irq[g] = |stretch;
  end

  assign press_irq   = lane_irq[0];
  assign release_irq = lane_irq[1];

endmodule

`default_nettype wire

// ==== logic/ref_status_sync.sv ====
// ------------------------------------------------------------
// Inputs come from GPS and TCXO clock domains and are slow
// Status bits are synced one by one, not as a coherent word
// ------------------------------------------------------------
`default_nettype none

`include "e300_glue_config.svh"

module ref_status_sync (
  input  logic                       bus_clk,
  input  logic                       bus_rst,
  input  logic                       gps_pps,
  input  e300_glue_pkg::ref_status_t ref_status,
  output logic                       pps_gpio,
  output e300_glue_pkg::ref_status_t tcxo_status
);

  logic [`E300_PPS_SYNC_STAGES-1:0] pps_pipe;
  e300_glue_pkg::ref_status_t       status_pipe [`E300_STATUS_SYNC_STAGES];

  // PPS chain, the extra stage gives more settling time
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      pps_pipe <= '0;
    end else begin
      pps_pipe <= {pps_pipe[`E300_PPS_SYNC_STAGES-2:0], gps_pps};
    end
  end

  // Reference status chain
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      for (int s = 0; s < `E300_STATUS_SYNC_STAGES; s++) begin
        status_pipe[s] <= '0;
      end
    end else begin
      status_pipe[0] <= ref_status;
      for (int s = 1; s < `E300_STATUS_SYNC_STAGES; s++) begin
        status_pipe[s] <= status_pipe[s-1];
      end
    end
  end

  // GPIO bit for ntpd
  assign pps_gpio    = pps_pipe[`E300_PPS_SYNC_STAGES-1];
  assign tcxo_status = status_pipe[`E300_STATUS_SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== logic/cat_interface.sv ====
// ------------------------------------------------------------
// Purely combinational path to the AD9361
// Software must keep the soft SPI core idle while PS SPI runs
// ------------------------------------------------------------
`default_nettype none

`include "e300_glue_config.svh"

module cat_interface (
  input  logic                    bus_rst,
  input  e300_glue_pkg::spi_bus_t ps_spi,
  input  e300_glue_pkg::spi_bus_t soft_spi,
  input  logic                    cat_miso,
  input  e300_glue_pkg::iq_t      rx_iq0,
  input  e300_glue_pkg::iq_t      rx_iq1,
  input  e300_glue_pkg::word_t    tx_data0,
  input  e300_glue_pkg::word_t    tx_data1,
  output e300_glue_pkg::spi_bus_t cat_spi,
  output logic                    ps_miso,
  output logic                    soft_miso,
  output logic                    cat_reset_n,
  output e300_glue_pkg::word_t    rx_data0,
  output e300_glue_pkg::word_t    rx_data1,
  output e300_glue_pkg::iq_t      tx_iq0,
  output e300_glue_pkg::iq_t      tx_iq1
);

  // ------------------------------------------------------------
  // Sample word format
  // ------------------------------------------------------------

  // i, pad, q, pad from the MSB down
  function automatic e300_glue_pkg::word_t pack_iq(input e300_glue_pkg::iq_t s);
    return {s.i, {`E300_PAD_WIDTH{1'b0}}, s.q, {`E300_PAD_WIDTH{1'b0}}};
  endfunction

  // Pad bits are dropped on the way back
  function automatic e300_glue_pkg::iq_t unpack_word(input e300_glue_pkg::word_t w);
    e300_glue_pkg::iq_t s;
    s.i = w[`E300_WORD_WIDTH-1 -: `E300_SAMPLE_WIDTH];
    s.q = w[`E300_PAD_WIDTH +: `E300_SAMPLE_WIDTH];
    return s;
  endfunction

  // ------------------------------------------------------------
  // SPI arbitration
  // ------------------------------------------------------------

  logic ps_selected;

  // PS SPI wins whenever its select is low, its clock is always stable
  assign ps_selected = ~ps_spi.sen;
  assign cat_spi     = ps_selected ? ps_spi : soft_spi;

  // Both masters listen to the same MISO line
  assign ps_miso   = cat_miso;
  assign soft_miso = cat_miso;

  // AD9361 reset pin is active low
  assign cat_reset_n = ~bus_rst;

  // ------------------------------------------------------------
  // Sample paths
  // ------------------------------------------------------------

  // Core channels are crossed with respect to the transceiver ports
  assign rx_data0 = pack_iq(rx_iq1);
  assign rx_data1 = pack_iq(rx_iq0);

  assign tx_iq1 = unpack_word(tx_data0);
  assign tx_iq0 = unpack_word(tx_data1);

endmodule

`default_nettype wire

// ==== logic/e300_glue.sv ====
// ------------------------------------------------------------
// Single clock domain, bus_rst is synchronous and active high
// stream_irq and pmu_irq pass straight into the vector
// ------------------------------------------------------------
`default_nettype none

module e300_glue (
  input  logic                       bus_clk,
  input  logic                       bus_rst,
  input  logic                       onswitch,
  input  logic                       gps_pps,
  input  logic                       stream_irq,
  input  logic                       pmu_irq,
  input  e300_glue_pkg::ref_status_t ref_status,
  input  e300_glue_pkg::spi_bus_t    ps_spi,
  input  e300_glue_pkg::spi_bus_t    soft_spi,
  input  logic                       cat_miso,
  input  e300_glue_pkg::iq_t         rx_iq0,
  input  e300_glue_pkg::iq_t         rx_iq1,
  input  e300_glue_pkg::word_t       tx_data0,
  input  e300_glue_pkg::word_t       tx_data1,
  output e300_glue_pkg::spi_bus_t    cat_spi,
  output logic                       ps_miso,
  output logic                       soft_miso,
  output logic                       cat_reset_n,
  output logic                       pps_gpio,
  output e300_glue_pkg::ref_status_t tcxo_status,
  output e300_glue_pkg::word_t       rx_data0,
  output e300_glue_pkg::word_t       rx_data1,
  output e300_glue_pkg::iq_t         tx_iq0,
  output e300_glue_pkg::iq_t         tx_iq1,
  output e300_glue_pkg::irq_vec_t    irq_vec
);

  logic press_irq;
  logic release_irq;

  // Front-panel button
  button_irq u_button_irq (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch    (onswitch),
    .press_irq   (press_irq),
    .release_irq (release_irq)
  );

  // PPS and reference status into bus_clk
  ref_status_sync u_ref_status_sync (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .gps_pps     (gps_pps),
    .ref_status  (ref_status),
    .pps_gpio    (pps_gpio),
    .tcxo_status (tcxo_status)
  );

  // Transceiver SPI and sample words
  cat_interface u_cat_interface (
    .bus_rst     (bus_rst),
    .ps_spi      (ps_spi),
    .soft_spi    (soft_spi),
    .cat_miso    (cat_miso),
    .rx_iq0      (rx_iq0),
    .rx_iq1      (rx_iq1),
    .tx_data0    (tx_data0),
    .tx_data1    (tx_data1),
    .cat_spi     (cat_spi),
    .ps_miso     (ps_miso),
    .soft_miso   (soft_miso),
    .cat_reset_n (cat_reset_n),
    .rx_data0    (rx_data0),
    .rx_data1    (rx_data1),
    .tx_iq0      (tx_iq0),
    .tx_iq1      (tx_iq1)
  );

  // Same bit order as the PS fabric interrupt inputs
  assign irq_vec = {pmu_irq, release_irq, press_irq, stream_irq};

endmodule

`default_nettype wire

// ==== dv/e300_glue_asserts.sv ====
// ------------------------------------------------------------
// Bound into e300_glue and sees only its ports
// Stretch checks need same-lane switch edges over 8 cycles apart
// ------------------------------------------------------------
`default_nettype none

`include "e300_glue_config.svh"

module e300_glue_asserts (
  input logic bus_clk, bus_rst, onswitch, gps_pps, stream_irq, pmu_irq,
  input logic cat_miso, ps_miso, soft_miso, cat_reset_n, pps_gpio,
  input e300_glue_pkg::ref_status_t ref_status, tcxo_status,
  input e300_glue_pkg::spi_bus_t    ps_spi, soft_spi, cat_spi,
  input e300_glue_pkg::iq_t         rx_iq0, rx_iq1, tx_iq0, tx_iq1,
  input e300_glue_pkg::word_t       tx_data0, tx_data1, rx_data0, rx_data1,
  input e300_glue_pkg::irq_vec_t    irq_vec
);
  timeunit 1ns;
  timeprecision 100ps;

  // Details of the first failed check
  logic  fail_seen = 1'b0;
  string fail_text;

  function automatic void note_event(string text);
    if (!fail_seen) begin
      fail_text = text;
      fail_seen = 1'b1;
    end
    $error("%s", text);
  endfunction

  function automatic void note_value(string name, logic [63:0] got, logic [63:0] exp);
    note_event($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
  endfunction

  // ------------------------------------------------------------
  // Registered paths
  // ------------------------------------------------------------

  sync_delay: assert property (@(posedge bus_clk) disable iff (bus_rst)
    {pps_gpio, tcxo_status} ==
      {$past(gps_pps, `E300_PPS_SYNC_STAGES), $past(ref_status, `E300_STATUS_SYNC_STAGES)})
    else note_value("{pps_gpio, tcxo_status}", 64'($sampled({pps_gpio, tcxo_status})),
      64'({$past(gps_pps, `E300_PPS_SYNC_STAGES), $past(ref_status, `E300_STATUS_SYNC_STAGES)}));

  reset_clear: assert property (@(posedge bus_clk)
    bus_rst |=> !pps_gpio && tcxo_status == '0 && irq_vec[2:1] == '0)
    else note_event("Synchronizer or button outputs not cleared by bus_rst");

  // Press is low after two high samples and release the mirror
  press_pulse: assert property (@(posedge bus_clk) disable iff (bus_rst)
    !onswitch && $past(onswitch) && $past(onswitch, 2)
      |=> irq_vec[1] [*`E300_STRETCH_CYCLES] ##1 !irq_vec[1])
    else note_event("press_irq did not pulse for exactly 8 cycles after a press");

  release_pulse: assert property (@(posedge bus_clk) disable iff (bus_rst)
    onswitch && !$past(onswitch) && !$past(onswitch, 2)
      |=> irq_vec[2] [*`E300_STRETCH_CYCLES] ##1 !irq_vec[2])
    else note_event("release_irq did not pulse for exactly 8 cycles after a release");

  // ------------------------------------------------------------
  // Combinational paths
  // ------------------------------------------------------------

  spi_route: assert property (@(posedge bus_clk)
    {cat_spi, ps_miso, soft_miso} == {(ps_spi.sen ? soft_spi : ps_spi), cat_miso, cat_miso})
    else note_value("{cat_spi, ps_miso, soft_miso}",
      64'($sampled({cat_spi, ps_miso, soft_miso})),
      64'($sampled({(ps_spi.sen ? soft_spi : ps_spi), cat_miso, cat_miso})));

  // Core channel 0 comes from transceiver channel 1
  rx_pack: assert property (@(posedge bus_clk)
    {rx_data0, rx_data1} == {rx_iq1.i, 4'h0, rx_iq1.q, 4'h0, rx_iq0.i, 4'h0, rx_iq0.q, 4'h0})
    else note_value("{rx_data0, rx_data1}", $sampled({rx_data0, rx_data1}),
      $sampled({rx_iq1.i, 4'h0, rx_iq1.q, 4'h0, rx_iq0.i, 4'h0, rx_iq0.q, 4'h0}));

  tx_unpack: assert property (@(posedge bus_clk)
    {tx_iq1, tx_iq0} == {tx_data0[31:20], tx_data0[15:4], tx_data1[31:20], tx_data1[15:4]})
    else note_value("{tx_iq1, tx_iq0}", 64'($sampled({tx_iq1, tx_iq0})),
      64'($sampled({tx_data0[31:20], tx_data0[15:4], tx_data1[31:20], tx_data1[15:4]})));

  irq_passthru: assert property (@(posedge bus_clk)
    {irq_vec[3], irq_vec[0], cat_reset_n} == {pmu_irq, stream_irq, !bus_rst})
    else note_value("{irq_vec[3], irq_vec[0], cat_reset_n}",
      64'($sampled({irq_vec[3], irq_vec[0], cat_reset_n})),
      64'($sampled({pmu_irq, stream_irq, !bus_rst})));

endmodule

`default_nettype wire

// ==== dv/e300_glue_tb.sv ====
// ------------------------------------------------------------
// All checking is done by the bound assertion module
// Switch levels are held 10 or more cycles, except the short
// press and release that run into the second reset
// ------------------------------------------------------------
`default_nettype none

module e300_glue_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period    = 20;
  localparam int reset_cycles  = 3;
  localparam int button_pairs  = 3;
  localparam int max_hold      = 17;
  localparam int random_cycles = 300;
  localparam int edge_cycles   = 4;
  localparam int tail_cycles   = 12;
  localparam int stim_cycles   = 2 * reset_cycles + (2 * button_pairs + 1) * max_hold +
                                 random_cycles + edge_cycles + tail_cycles;

  logic bus_clk, bus_rst, onswitch, gps_pps, stream_irq, pmu_irq, cat_miso;
  logic ps_miso, soft_miso, cat_reset_n, pps_gpio;
  e300_glue_pkg::ref_status_t ref_status, tcxo_status;
  e300_glue_pkg::spi_bus_t    ps_spi, soft_spi, cat_spi;
  e300_glue_pkg::iq_t         rx_iq0, rx_iq1, tx_iq0, tx_iq1;
  e300_glue_pkg::word_t       tx_data0, tx_data1, rx_data0, rx_data1;
  e300_glue_pkg::irq_vec_t    irq_vec;
  integer                     seed = 14325;

  e300_glue u_dut (.*);

  bind e300_glue e300_glue_asserts u_asserts (.*);

  always #(clk_period / 2) bus_clk = ~bus_clk;

  // ------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------

  // Synchronizer inputs and switch parked low so history matches reset
  task automatic apply_reset();
    bus_rst    <= 1'b1;
    onswitch   <= 1'b0;
    gps_pps    <= 1'b0;
    ref_status <= '0;
    repeat (reset_cycles) @(posedge bus_clk);
    bus_rst <= 1'b0;
  endtask

  // Hold for 10 to 17 cycles
  task automatic hold_switch(input logic level);
    int hold;
    hold = 10 + ($random(seed) & 7);
    onswitch <= level;
    repeat (hold) @(posedge bus_clk);
  endtask

  task automatic drive_random();
    gps_pps    <= 1'($random(seed));
    ref_status <= 4'($random(seed));
    ps_spi     <= 3'($random(seed));
    soft_spi   <= 3'($random(seed));
    cat_miso   <= 1'($random(seed));
    stream_irq <= 1'($random(seed));
    pmu_irq    <= 1'($random(seed));
    rx_iq0     <= 24'($random(seed));
    rx_iq1     <= 24'($random(seed));
    tx_data0   <= $random(seed);
    tx_data1   <= $random(seed);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    bus_clk    = 1'b0;
    bus_rst    = 1'b1;
    onswitch   = 1'b0;
    gps_pps    = 1'b0;
    stream_irq = 1'b0;
    pmu_irq    = 1'b0;
    cat_miso   = 1'b0;
    ref_status = '0;
    ps_spi     = '0;
    soft_spi   = '0;
    rx_iq0     = '0;
    rx_iq1     = '0;
    tx_data0   = '0;
    tx_data1   = '0;
    apply_reset();
    for (int p = 0; p < button_pairs; p++) begin
      hold_switch(1'b1);
      hold_switch(1'b0);
    end
    hold_switch(1'b1);
    repeat (random_cycles) begin
      @(posedge bus_clk);
      drive_random();
    end
    // Both stretch lanes still busy when the second reset arrives
    onswitch <= 1'b0;
    repeat (2) @(posedge bus_clk);
    onswitch <= 1'b1;
    repeat (2) @(posedge bus_clk);
    // Second reset with traffic still on the combinational inputs
    apply_reset();
    repeat (tail_cycles) @(posedge bus_clk);
    if (u_dut.u_asserts.fail_seen) begin
      $display("TEST FAILED");
      $fatal(1, "Assertion failure seen at end of run");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  initial begin
    wait (u_dut.u_asserts.fail_seen);
    $display("%s", u_dut.u_asserts.fail_text);
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first failed assertion");
  end

  // Twice the longest possible stimulus
  initial begin
    #(2 * stim_cycles * clk_period);
    $display("Timeout: stimulus did not finish within %0d ns", 2 * stim_cycles * clk_period);
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/e300_glue_pkg.sv
logic/button_irq.sv
logic/ref_status_sync.sv
logic/cat_interface.sv
logic/e300_glue.sv
dv/e300_glue_asserts.sv
dv/e300_glue_tb.sv
